/* src/csr_pkg.sv */
package csr_pkg;

    typedef logic [8:0]  csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [25:0] entry_va_t;
    typedef logic [29:0] timer_init_t;

    // CSR numbers
    localparam csr_num_t CSR_CRMD   = 9'h000;
    localparam csr_num_t CSR_PRMD   = 9'h001;
    localparam csr_num_t CSR_ECFG   = 9'h004;
    localparam csr_num_t CSR_ESTAT  = 9'h005;
    localparam csr_num_t CSR_ERA    = 9'h006;
    localparam csr_num_t CSR_BADV   = 9'h007;
    localparam csr_num_t CSR_EENTRY = 9'h00c;
    localparam csr_num_t CSR_SAVE0  = 9'h030;
    localparam csr_num_t CSR_SAVE1  = 9'h031;
    localparam csr_num_t CSR_SAVE2  = 9'h032;
    localparam csr_num_t CSR_SAVE3  = 9'h033;
    localparam csr_num_t CSR_TCFG   = 9'h041;
    localparam csr_num_t CSR_TICLR  = 9'h044;

    // Field positions
    localparam int CRMD_PLV_LO       = 0;
    localparam int CRMD_PLV_HI       = 1;
    localparam int CRMD_IE           = 2;
    localparam int CRMD_DA           = 3;
    localparam int PRMD_PPLV_LO      = 0;
    localparam int PRMD_PPLV_HI      = 1;
    localparam int PRMD_PIE          = 2;
    localparam int ECFG_LIE_LO       = 0;
    localparam int ECFG_LIE_HI       = 12;
    localparam int ESTAT_IS_LO       = 0;
    localparam int ESTAT_IS_HI       = 12;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;
    localparam int TCFG_EN           = 0;
    localparam int TCFG_PERIODIC     = 1;
    localparam int TCFG_INITVAL_LO   = 2;
    localparam int TCFG_INITVAL_HI   = 31;
    localparam int TICLR_CLR         = 0;
    localparam int ENTRY_LOW_BITS    = 6;

    // Exception codes
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    // Timer parks here once a one-shot count has expired
    localparam csr_word_t TIMER_IDLE    = 32'hffff_ffff;
    localparam int        TIMER_INT_BIT = 11;

endpackage

/* src/csr_exception_regs.sv */
`timescale 1ns/10ps

module csr_exception_regs (
    input  logic                clock,
    input  logic                reset,
    input  csr_pkg::csr_num_t   csr_num,
    input  logic                csr_we,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    input  logic                wb_ex,
    input  logic                ertn_flush,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    input  csr_pkg::csr_word_t  wb_vaddr,
    input  logic [7:0]          hw_int_in,
    input  logic                ipi_int_in,
    output csr_pkg::plv_t       crmd_plv,
    output logic                crmd_ie,
    output logic                crmd_da,
    output csr_pkg::plv_t       prmd_pplv,
    output logic                prmd_pie,
    output csr_pkg::int_vec_t   ecfg_lie,
    output csr_pkg::int_vec_t   estat_is_low,
    output csr_pkg::ecode_t     estat_ecode,
    output csr_pkg::esubcode_t  estat_esubcode,
    output csr_pkg::csr_word_t  era_pc,
    output csr_pkg::csr_word_t  badv_vaddr,
    output csr_pkg::entry_va_t  eentry_va,
    output csr_pkg::csr_word_t  save0,
    output csr_pkg::csr_word_t  save1,
    output csr_pkg::csr_word_t  save2,
    output csr_pkg::csr_word_t  save3
);
    import csr_pkg::*;

    logic [1:0] is_sw;
    logic [7:0] is_hw;
    logic       is_ipi;
    logic       addr_err;

    // Software interrupt bits from ESTAT writes, lines sampled every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            is_sw <= 2'b00;
        end else if (csr_we && csr_num == CSR_ESTAT) begin
            is_sw <= (csr_wvalue[ESTAT_IS_LO +: 2] & csr_wmask[ESTAT_IS_LO +: 2])
                   | (is_sw & ~csr_wmask[ESTAT_IS_LO +: 2]);
        end
        is_hw  <= hw_int_in;
        is_ipi <= ipi_int_in;
    end

    // Bit 11 is the timer, merged in the readout
    assign estat_is_low = {is_ipi, 1'b0, 1'b0, is_hw, is_sw};

    always_ff @(posedge clock) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
            ecfg_lie <= '0;
        end else begin
            if (wb_ex) begin
                crmd_plv <= '0;
                crmd_ie  <= 1'b0;
            end else if (ertn_flush) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (csr_we && csr_num == CSR_CRMD) begin
                crmd_plv <= (csr_wvalue[CRMD_PLV_HI:CRMD_PLV_LO]
                             & csr_wmask[CRMD_PLV_HI:CRMD_PLV_LO])
                          | (crmd_plv & ~csr_wmask[CRMD_PLV_HI:CRMD_PLV_LO]);
                crmd_ie  <= csr_wmask[CRMD_IE] ? csr_wvalue[CRMD_IE] : crmd_ie;
            end
            if (csr_we && csr_num == CSR_CRMD) begin
                crmd_da <= csr_wmask[CRMD_DA] ? csr_wvalue[CRMD_DA] : crmd_da;
            end
            if (csr_we && csr_num == CSR_ECFG) begin
                ecfg_lie <= (csr_wvalue[ECFG_LIE_HI:ECFG_LIE_LO]
                             & csr_wmask[ECFG_LIE_HI:ECFG_LIE_LO])
                          | (ecfg_lie & ~csr_wmask[ECFG_LIE_HI:ECFG_LIE_LO]);
            end
        end
    end

    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    always_ff @(posedge clock) begin
        if (wb_ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_pc         <= wb_pc;
        end else begin
            if (csr_we && csr_num == CSR_PRMD) begin
                prmd_pplv <= (csr_wvalue[PRMD_PPLV_HI:PRMD_PPLV_LO]
                              & csr_wmask[PRMD_PPLV_HI:PRMD_PPLV_LO])
                           | (prmd_pplv & ~csr_wmask[PRMD_PPLV_HI:PRMD_PPLV_LO]);
                prmd_pie  <= csr_wmask[PRMD_PIE] ? csr_wvalue[PRMD_PIE] : prmd_pie;
            end
            if (csr_we && csr_num == CSR_ERA) begin
                era_pc <= (csr_wvalue & csr_wmask) | (era_pc & ~csr_wmask);
            end
        end
        // Fetch address faults report the PC itself
        if (wb_ex && addr_err) begin
            badv_vaddr <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ?
                          wb_pc : wb_vaddr;
        end
    end

    always_ff @(posedge clock) begin
        if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= (csr_wvalue[31:ENTRY_LOW_BITS] & csr_wmask[31:ENTRY_LOW_BITS])
                       | (eentry_va & ~csr_wmask[31:ENTRY_LOW_BITS]);
        end
        if (csr_we && csr_num == CSR_SAVE0) begin
            save0 <= (csr_wvalue & csr_wmask) | (save0 & ~csr_wmask);
        end
        if (csr_we && csr_num == CSR_SAVE1) begin
            save1 <= (csr_wvalue & csr_wmask) | (save1 & ~csr_wmask);
        end
        if (csr_we && csr_num == CSR_SAVE2) begin
            save2 <= (csr_wvalue & csr_wmask) | (save2 & ~csr_wmask);
        end
        if (csr_we && csr_num == CSR_SAVE3) begin
            save3 <= (csr_wvalue & csr_wmask) | (save3 & ~csr_wmask);
        end
    end

endmodule

/* src/csr_timer.sv */
`timescale 1ns/10ps

module csr_timer (
    input  logic                clock,
    input  logic                reset,
    input  csr_pkg::csr_num_t   csr_num,
    input  logic                csr_we,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    output logic                timer_int
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    timer_init_t tcfg_initval;
    csr_word_t   tcfg_cur;
    csr_word_t   tcfg_next;
    csr_word_t   timer_cnt;
    logic        wr_tcfg;
    logic        clr_int;

    assign wr_tcfg = csr_we && (csr_num == CSR_TCFG);
    assign clr_int = csr_we && (csr_num == CSR_TICLR)
                  && csr_wmask[TICLR_CLR] && csr_wvalue[TICLR_CLR];

    always_comb begin
        tcfg_cur                                   = '0;
        tcfg_cur[TCFG_EN]                          = tcfg_en;
        tcfg_cur[TCFG_PERIODIC]                    = tcfg_periodic;
        tcfg_cur[TCFG_INITVAL_HI:TCFG_INITVAL_LO] = tcfg_initval;
    end

    // TCFG as it will be after this cycle's write
    assign tcfg_next = (csr_wvalue & csr_wmask) | (tcfg_cur & ~csr_wmask);

    always_ff @(posedge clock) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (wr_tcfg) begin
            tcfg_en <= tcfg_next[TCFG_EN];
        end
        if (wr_tcfg) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[TCFG_INITVAL_HI:TCFG_INITVAL_LO];
        end
    end

    // One-shot count wraps from 0 to the idle value and stops there
    always_ff @(posedge clock) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next[TCFG_EN]) begin
            timer_cnt <= {tcfg_next[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b00};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (clr_int) begin
            timer_int <= 1'b0;
        end
    end

endmodule

/* src/csr_readout_int.sv */
`timescale 1ns/10ps

module csr_readout_int (
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::plv_t       crmd_plv,
    input  logic                crmd_ie,
    input  logic                crmd_da,
    input  csr_pkg::plv_t       prmd_pplv,
    input  logic                prmd_pie,
    input  csr_pkg::int_vec_t   ecfg_lie,
    input  csr_pkg::int_vec_t   estat_is_low,
    input  csr_pkg::ecode_t     estat_ecode,
    input  csr_pkg::esubcode_t  estat_esubcode,
    input  csr_pkg::csr_word_t  era_pc,
    input  csr_pkg::csr_word_t  badv_vaddr,
    input  csr_pkg::entry_va_t  eentry_va,
    input  csr_pkg::csr_word_t  save0,
    input  csr_pkg::csr_word_t  save1,
    input  csr_pkg::csr_word_t  save2,
    input  csr_pkg::csr_word_t  save3,
    input  logic                timer_int,
    output csr_pkg::csr_word_t  csr_rvalue,
    output logic                has_int,
    output csr_pkg::csr_word_t  ex_entry
);
    import csr_pkg::*;

    int_vec_t  estat_is;
    csr_word_t crmd_word;
    csr_word_t prmd_word;
    csr_word_t ecfg_word;
    csr_word_t estat_word;

    always_comb begin
        estat_is                = estat_is_low;
        estat_is[TIMER_INT_BIT] = timer_int;

        crmd_word                          = '0;
        crmd_word[CRMD_PLV_HI:CRMD_PLV_LO] = crmd_plv;
        crmd_word[CRMD_IE]                 = crmd_ie;
        crmd_word[CRMD_DA]                 = crmd_da;

        prmd_word                            = '0;
        prmd_word[PRMD_PPLV_HI:PRMD_PPLV_LO] = prmd_pplv;
        prmd_word[PRMD_PIE]                  = prmd_pie;

        ecfg_word                          = '0;
        ecfg_word[ECFG_LIE_HI:ECFG_LIE_LO] = ecfg_lie;

        estat_word                                     = '0;
        estat_word[ESTAT_IS_HI:ESTAT_IS_LO]            = estat_is;
        estat_word[ESTAT_ECODE_HI:ESTAT_ECODE_LO]      = estat_ecode;
        estat_word[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO] = estat_esubcode;
    end

    assign ex_entry = {eentry_va, {ENTRY_LOW_BITS{1'b0}}};

    // IPI at bit 12 does not request an interrupt
    assign has_int = (|(estat_is[TIMER_INT_BIT:0] & ecfg_lie[TIMER_INT_BIT:0])) && crmd_ie;

    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_word;
            CSR_PRMD:   csr_rvalue = prmd_word;
            CSR_ECFG:   csr_rvalue = ecfg_word;
            CSR_ESTAT:  csr_rvalue = estat_word;
            CSR_ERA:    csr_rvalue = era_pc;
            CSR_BADV:   csr_rvalue = badv_vaddr;
            CSR_EENTRY: csr_rvalue = ex_entry;
            CSR_SAVE0:  csr_rvalue = save0;
            CSR_SAVE1:  csr_rvalue = save1;
            CSR_SAVE2:  csr_rvalue = save2;
            CSR_SAVE3:  csr_rvalue = save3;
            // Clear-only register
            CSR_TICLR:  csr_rvalue = '0;
            default:    csr_rvalue = '0;
        endcase
    end

endmodule

/* src/csr_file.sv */
`timescale 1ns/10ps

module csr_file (
    input  logic                clock,
    input  logic                reset,
    input  csr_pkg::csr_num_t   csr_num,
    input  logic                csr_we,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    output csr_pkg::csr_word_t  csr_rvalue,
    input  logic [7:0]          hw_int_in,
    input  logic                ipi_int_in,
    output csr_pkg::csr_word_t  ex_entry,
    output logic                has_int,
    input  logic                ertn_flush,
    input  logic                wb_ex,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    input  csr_pkg::csr_word_t  wb_vaddr
);
    import csr_pkg::*;

    plv_t      crmd_plv;
    logic      crmd_ie;
    logic      crmd_da;
    plv_t      prmd_pplv;
    logic      prmd_pie;
    int_vec_t  ecfg_lie;
    int_vec_t  estat_is_low;
    ecode_t    estat_ecode;
    esubcode_t estat_esubcode;
    csr_word_t era_pc;
    csr_word_t badv_vaddr;
    entry_va_t eentry_va;
    csr_word_t save0;
    csr_word_t save1;
    csr_word_t save2;
    csr_word_t save3;
    logic      timer_int;

    csr_exception_regs u_exception_regs (
        .clock          (clock),
        .reset          (reset),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .wb_pc          (wb_pc),
        .wb_vaddr       (wb_vaddr),
        .hw_int_in      (hw_int_in),
        .ipi_int_in     (ipi_int_in),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .crmd_da        (crmd_da),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is_low   (estat_is_low),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3)
    );

    csr_timer u_timer (
        .clock      (clock),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .timer_int  (timer_int)
    );

    csr_readout_int u_readout (
        .csr_num        (csr_num),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .crmd_da        (crmd_da),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is_low   (estat_is_low),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .timer_int      (timer_int),
        .csr_rvalue     (csr_rvalue),
        .has_int        (has_int),
        .ex_entry       (ex_entry)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock
);
    // 4 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

endmodule

/* testbench/csr_checker.sv */
`timescale 1ns/10ps

module csr_checker (
    input  logic                clock,
    input  csr_pkg::csr_num_t   csr_num,
    input  csr_pkg::csr_word_t  csr_rvalue,
    input  logic                has_int,
    input  csr_pkg::csr_word_t  ex_entry,
    input  logic                check_read,
    input  csr_pkg::csr_word_t  expect_rvalue,
    input  logic                check_int,
    input  logic                expect_int,
    output int                  error_count
);
    import csr_pkg::*;

    int errors = 0;

    assign error_count = errors;

    // Inputs change 1 ns after the rising edge, so the falling edge sees settled outputs
    always @(negedge clock) begin
        if (check_read && csr_rvalue !== expect_rvalue) begin
            errors = errors + 1;
            $display("** Error at %0t: CSR 0x%03h read 0x%08h, expected 0x%08h",
                     $time, csr_num, csr_rvalue, expect_rvalue);
        end
        // EENTRY reads back exactly as the entry address
        if (check_read && csr_num == CSR_EENTRY && ex_entry !== expect_rvalue) begin
            errors = errors + 1;
            $display("** Error at %0t: ex_entry is 0x%08h, expected 0x%08h",
                     $time, ex_entry, expect_rvalue);
        end
        if (check_int && has_int !== expect_int) begin
            errors = errors + 1;
            $display("** Error at %0t: has_int is %b, expected %b",
                     $time, has_int, expect_int);
        end
    end

endmodule

/* testbench/csr_file_tb.sv */
`timescale 1ns/10ps

module csr_file_tb;
    import csr_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_CASE = 200;

    logic       clock;
    logic       reset;
    csr_num_t   csr_num;
    logic       csr_we;
    csr_word_t  csr_wmask;
    csr_word_t  csr_wvalue;
    csr_word_t  csr_rvalue;
    logic [7:0] hw_int_in;
    logic       ipi_int_in;
    csr_word_t  ex_entry;
    logic       has_int;
    logic       ertn_flush;
    logic       wb_ex;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    csr_word_t  wb_pc;
    csr_word_t  wb_vaddr;

    logic       check_read;
    csr_word_t  expect_rvalue;
    logic       check_int;
    logic       expect_int;
    int         checker_errors;
    int         other_failures;
    int         case_count;
    logic       cases_loaded;

    byte        case_op[$];
    csr_word_t  case_a[$];
    csr_word_t  case_b[$];
    csr_word_t  case_c[$];
    csr_word_t  case_d[$];

    tb_clock_gen u_clock_gen (
        .clock (clock)
    );

    csr_file i_csr_file (
        .clock       (clock),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .csr_rvalue  (csr_rvalue),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .ex_entry    (ex_entry),
        .has_int     (has_int),
        .ertn_flush  (ertn_flush),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr)
    );

    csr_checker u_checker (
        .clock         (clock),
        .csr_num       (csr_num),
        .csr_rvalue    (csr_rvalue),
        .has_int       (has_int),
        .ex_entry      (ex_entry),
        .check_read    (check_read),
        .expect_rvalue (expect_rvalue),
        .check_int     (check_int),
        .expect_int    (expect_int),
        .error_count   (checker_errors)
    );

    task automatic load_cases(output bit opened);
        int        fd;
        int        code;
        byte       op;
        string     skipped;
        csr_word_t a;
        csr_word_t b;
        csr_word_t c;
        csr_word_t d;
        fd = $fopen("testbench/csr_cases.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", op);
                if (code == 1) begin
                    a = '0;
                    b = '0;
                    c = '0;
                    d = '0;
                    case (op)
                        "#": code = $fgets(skipped, fd);
                        "W": code = $fscanf(fd, "%h %h %h", a, b, c);
                        "R": code = $fscanf(fd, "%h %h", a, b);
                        "X": code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                        "H": code = $fscanf(fd, "%h %h", a, b);
                        "I": code = $fscanf(fd, "%h", a);
                        "P": code = $fscanf(fd, "%h %d %d", a, b, c);
                        default: code = 0;
                    endcase
                    if (op != "#") begin
                        case_op.push_back(op);
                        case_a.push_back(a);
                        case_b.push_back(b);
                        case_c.push_back(c);
                        case_d.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // Waits for a CSR bit to read as 1, checked once per cycle
    task automatic poll_bit(input csr_num_t num, input int bit_index, input int bound);
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        csr_num = num;
        while (!seen && waited <= bound) begin
            @(negedge clock);
            seen = (csr_rvalue[bit_index] === 1'b1);
            next_cycle();
            waited = waited + 1;
        end
        if (!seen) begin
            other_failures = other_failures + 1;
            $display("Bit %0d of CSR 0x%03h did not set within %0d cycles at %0t",
                     bit_index, num, bound, $time);
        end
    endtask

    task automatic run_case(input byte op, input csr_word_t a, input csr_word_t b,
                            input csr_word_t c, input csr_word_t d);
        case (op)
            "W": begin
                csr_num = a[8:0];
                csr_wmask = b;
                csr_wvalue = c;
                csr_we = 1'b1;
                next_cycle();
                csr_we = 1'b0;
            end
            "R": begin
                csr_num = a[8:0];
                expect_rvalue = b;
                check_read = 1'b1;
                next_cycle();
                check_read = 1'b0;
            end
            "X": begin
                wb_ecode = a[5:0];
                wb_esubcode = b[8:0];
                wb_pc = c;
                wb_vaddr = d;
                wb_ex = 1'b1;
                next_cycle();
                wb_ex = 1'b0;
            end
            "E": begin
                ertn_flush = 1'b1;
                next_cycle();
                ertn_flush = 1'b0;
            end
            "H": begin
                hw_int_in = a[7:0];
                ipi_int_in = b[0];
                next_cycle();
            end
            "I": begin
                expect_int = a[0];
                check_int = 1'b1;
                next_cycle();
                check_int = 1'b0;
            end
            "P": poll_bit(a[8:0], b, c);
            default: begin
                other_failures = other_failures + 1;
                $display("Unknown operation '%c' in the case file", op);
            end
        endcase
    endtask

    initial begin
        bit opened;
        int idx;
        reset = 1'b1;
        csr_num = '0;
        csr_we = 1'b0;
        csr_wmask = '0;
        csr_wvalue = '0;
        hw_int_in = '0;
        ipi_int_in = 1'b0;
        ertn_flush = 1'b0;
        wb_ex = 1'b0;
        wb_ecode = '0;
        wb_esubcode = '0;
        wb_pc = '0;
        wb_vaddr = '0;
        check_read = 1'b0;
        expect_rvalue = '0;
        check_int = 1'b0;
        expect_int = 1'b0;
        other_failures = 0;
        case_count = 0;
        cases_loaded = 1'b0;
        load_cases(opened);
        if (!opened) begin
            $display("Could not open testbench/csr_cases.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            case_count = case_op.size();
            cases_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clock);
            #1;
            reset = 1'b0;
            for (idx = 0; idx < case_count; idx++) begin
                run_case(case_op[idx], case_a[idx], case_b[idx], case_c[idx], case_d[idx]);
            end
            $display("Errors: %0d value mismatches, %0d other failures over %0d cases",
                     checker_errors, other_failures, case_count);
            if (checker_errors == 0 && other_failures == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

    // Watchdog
    initial begin
        wait (cases_loaded);
        repeat (RESET_CYCLES + case_count * CYCLES_PER_CASE) @(posedge clock);
        $display("Timeout: the %0d cases did not finish in %0d cycles",
                 case_count, RESET_CYCLES + case_count * CYCLES_PER_CASE);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* testbench/csr_cases.txt */
# W num mask value | R num expect | X ecode esubcode pc vaddr | E | H hw ipi
# I has_int | P num bit cycles  (bit and cycles in decimal, all else hex)
R 0 00000008
R 4 00000000
I 0
W 30 ffffffff a5a5a5a5
W 30 00ff00ff 12345678
R 30 a534a578
W 33 ffffffff 0badf00d
W 33 ffff0000 5a5a1234
R 33 5a5af00d
W c ffffffff 1c0080ff
W c 0000ff00 00001234
R c 1c0012c0
W 4 0000000f 0000fff4
R 4 00000004
W 0 00000007 00000007
R 0 0000000f
X 9 0 1c000100 00000abc
R 5 00090000
R 6 1c000100
R 7 00000abc
R 1 00000007
R 0 00000008
E
R 0 0000000f
X 8 0 1c000200 deadbeef
R 7 1c000200
R 0 00000008
H 01 0
R 5 00080004
I 0
E
I 1
H 00 0
I 0
W 41 ffffffff 00000015
P 5 11 22
W 44 00000001 00000001
R 5 00080000
W 41 ffffffff 00000017
P 5 11 22
W 44 00000001 00000001
R 5 00080000
P 5 11 22

/* files.f */
src/csr_pkg.sv
src/csr_exception_regs.sv
src/csr_timer.sv
src/csr_readout_int.sv
src/csr_file.sv
testbench/tb_clock_gen.sv
testbench/csr_checker.sv
testbench/csr_file_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module csr_file_tb -f files.f \
    && ./obj_dir/Vcsr_file_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
